//--- cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int NUM_WAYS       = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int INDEX_W        = 8;    // addr[11:4]
    localparam int TAG_W          = 20;   // addr[31:12]
    localparam int OFFSET_W       = 4;    // addr[3:0]

    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [1:0]          word_sel_t;   // word within a line
    typedef logic [NUM_WAYS-1:0] way_mask_t;

    // tag in the upper bits, valid in bit 0
    typedef logic [TAG_W:0]      tagv_t;

    typedef enum logic [1:0] {
        idle,
        lookup,
        replace,
        refill
    } cache_state_t;

endpackage

`default_nettype wire

//--- mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [2:0]        req_type_t;

    // 000 byte, 001 half, 010 word, 100 whole line
    localparam req_type_t REQ_LINE = 3'b100;

endpackage

`default_nettype wire

//--- cache_sram.sv
`default_nettype none

module cache_sram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire cache_geom_pkg::index_t addr,
    input  wire                         we,
    input  wire [WIDTH-1:0]             din,
    output logic [WIDTH-1:0]            dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // write cycles leave dout holding the last read
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            dout <= '0;
        end else if (we) begin
            mem[addr] <= din;
        end else begin
            dout <= mem[addr];   // read data one cycle after addr
        end
    end

endmodule

`default_nettype wire

//--- cache_way.sv
`default_nettype none

module cache_way (
    input  wire                            clk,
    input  wire                            reset,
    // lookup
    input  wire cache_geom_pkg::index_t    lookup_index,
    input  wire cache_geom_pkg::tag_t      req_tag,
    input  wire cache_geom_pkg::word_sel_t word_sel,
    // refill
    input  wire                            refill_we,
    input  wire cache_geom_pkg::word_sel_t refill_word,
    input  wire mem_bus_pkg::word_t        refill_data,
    input  wire                            tag_we,
    // results
    output logic                           hit,
    output logic                           line_valid,
    output mem_bus_pkg::word_t             load_word
);

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    tagv_t tagv_q;
    word_t bank_q [WORDS_PER_LINE];

    // tag/valid array, written once the last beat of a refill arrives
    cache_sram #(
        .WIDTH ($bits(tagv_t)),
        .DEPTH (SETS)
    ) u_tagv (
        .clk   (clk),
        .reset (reset),
        .addr  (lookup_index),
        .we    (tag_we),
        .din   ({req_tag, 1'b1}),
        .dout  (tagv_q)
    );

    // one bank per word of the line
    for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
        cache_sram #(
            .WIDTH ($bits(word_t)),
            .DEPTH (SETS)
        ) u_bank (
            .clk   (clk),
            .reset (reset),
            .addr  (lookup_index),
            .we    (refill_we && (refill_word == word_sel_t'(b))),
            .din   (refill_data),
            .dout  (bank_q[b])
        );
    end

    assign line_valid = tagv_q[0];
    assign hit        = line_valid && (tagv_q[TAG_W:1] == req_tag);   // valid and tag match
    assign load_word  = bank_q[word_sel];

endmodule

`default_nettype wire

//--- victim_select.sv
`default_nettype none

module victim_select #(
    parameter logic [7:0] LFSR_SEED = 8'hAA   // any nonzero value
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire cache_geom_pkg::way_mask_t way_valid,
    output cache_geom_pkg::way_mask_t      victim
);

    import cache_geom_pkg::*;

    logic [7:0] lfsr;
    way_mask_t  free_ways;
    way_mask_t  first_free;
    way_mask_t  rand_way;

    // galois form, steps every cycle whether or not a miss is pending
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr[0] <= lfsr[7];
            lfsr[1] <= lfsr[0] ^ lfsr[6];
            lfsr[2] <= lfsr[1];
            lfsr[3] <= lfsr[2] ^ lfsr[4];
            lfsr[4] <= lfsr[3] ^ lfsr[7];
            lfsr[5] <= lfsr[4];
            lfsr[6] <= lfsr[5];
            lfsr[7] <= lfsr[6];
        end
    end

    assign free_ways  = ~way_valid;
    assign first_free = free_ways & (~free_ways + way_mask_t'(1));   // lowest set bit only
    assign rand_way   = way_mask_t'(1) << lfsr[5];

    // an empty way always wins over a random eviction
    assign victim = (|free_ways) ? first_free : rand_way;

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`default_nettype none

module cache_ctrl (
    input  wire                             clk,
    input  wire                             reset,

    // processor load port
    input  wire                             valid,
    input  wire cache_geom_pkg::index_t     index,
    input  wire cache_geom_pkg::tag_t       tag,
    input  wire cache_geom_pkg::offset_t    offset,
    output logic                            addr_ok,
    output logic                            data_ok,
    output mem_bus_pkg::word_t              rdata,

    // ways and victim selector
    input  wire cache_geom_pkg::way_mask_t  way_hit,
    input  wire mem_bus_pkg::word_t         way_load_word [cache_geom_pkg::NUM_WAYS],
    input  wire cache_geom_pkg::way_mask_t  victim,
    output cache_geom_pkg::index_t          lookup_index,
    output cache_geom_pkg::tag_t            req_tag,
    output cache_geom_pkg::word_sel_t       word_sel,
    output cache_geom_pkg::way_mask_t       refill_we,
    output cache_geom_pkg::word_sel_t       refill_word,
    output cache_geom_pkg::way_mask_t       tag_we,

    // memory bus
    output logic                            rd_req,
    output mem_bus_pkg::req_type_t          rd_type,
    output mem_bus_pkg::addr_t              rd_addr,
    input  wire                             rd_rdy,
    input  wire                             ret_valid,
    input  wire                             ret_last,
    input  wire mem_bus_pkg::word_t         ret_data
);

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    cache_state_t state;
    cache_state_t state_next;

    // request buffer
    index_t    req_index;
    offset_t   req_offset;

    way_mask_t miss_way;   // victim latched on the miss
    word_sel_t beat;       // refill beat number

    logic  cache_hit;
    logic  accept;
    logic  beat_in;
    word_t hit_word;

    assign cache_hit = |way_hit;

    // a buffered hit frees the buffer for the next request in the same cycle
    assign addr_ok = (state == idle) || ((state == lookup) && cache_hit);
    assign accept  = valid && addr_ok;

    // storage is read with the incoming index at the accepting edge
    assign lookup_index = addr_ok ? index : req_index;
    assign word_sel     = req_offset[OFFSET_W-1:OFFSET_W-$bits(word_sel_t)];

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (valid) begin
                    state_next = lookup;
                end
            end
            lookup: begin
                if (!cache_hit) begin
                    state_next = replace;
                end else if (!valid) begin
                    state_next = idle;   // no follow-on request
                end
            end
            replace: begin
                if (rd_rdy) begin
                    state_next = refill;
                end
            end
            refill: begin
                if (ret_valid && ret_last) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            miss_way <= '0;
            beat     <= '0;
        end else begin
            state <= state_next;
            if ((state == lookup) && !cache_hit) begin
                miss_way <= victim;
            end
            if (state == replace) begin
                beat <= '0;
            end else if (beat_in) begin
                beat <= beat + 1'b1;   // gaps in ret_valid hold the count
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
        end
    end

    // merge the hitting way's word
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_word = hit_word | way_load_word[w];
            end
        end
    end

    always_comb begin
        case (state)
            lookup:  rdata = hit_word;
            refill:  rdata = ret_data;   // requested word passes straight through
            default: rdata = '0;
        endcase
    end

    assign beat_in = (state == refill) && ret_valid;

    assign data_ok = ((state == lookup) && cache_hit) ||
                     (beat_in && (beat == word_sel));

    // refill writes go only to the latched victim way
    assign refill_we   = miss_way & {NUM_WAYS{beat_in}};
    assign refill_word = beat;
    assign tag_we      = miss_way & {NUM_WAYS{beat_in && ret_last}};

    assign rd_req  = (state == replace);
    assign rd_type = REQ_LINE;
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};   // line aligned

endmodule

`default_nettype wire

//--- icache_top.sv
`default_nettype none

module icache_top #(
    parameter logic [7:0] LFSR_SEED = 8'hAA
) (
    input  wire                          clk,
    input  wire                          reset,

    // processor load port
    input  wire                          valid,
    input  wire cache_geom_pkg::index_t  index,
    input  wire cache_geom_pkg::tag_t    tag,
    input  wire cache_geom_pkg::offset_t offset,
    output mem_bus_pkg::word_t           rdata,
    output logic                         addr_ok,
    output logic                         data_ok,

    // line read bus
    output logic                         rd_req,
    output mem_bus_pkg::req_type_t       rd_type,
    output mem_bus_pkg::addr_t           rd_addr,
    input  wire                          rd_rdy,
    input  wire                          ret_valid,
    input  wire                          ret_last,
    input  wire mem_bus_pkg::word_t      ret_data
);

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    wire index_t    lookup_index;
    wire tag_t      req_tag;
    wire word_sel_t word_sel;
    wire word_sel_t refill_word;
    wire way_mask_t refill_we;
    wire way_mask_t tag_we;
    wire way_mask_t way_hit;
    wire way_mask_t way_valid;
    wire way_mask_t victim;
    wire word_t     way_load_word [NUM_WAYS];

    cache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .index         (index),
        .tag           (tag),
        .offset        (offset),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .way_hit       (way_hit),
        .way_load_word (way_load_word),
        .victim        (victim),
        .lookup_index  (lookup_index),
        .req_tag       (req_tag),
        .word_sel      (word_sel),
        .refill_we     (refill_we),
        .refill_word   (refill_word),
        .tag_we        (tag_we),
        .rd_req        (rd_req),
        .rd_type       (rd_type),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .ret_data      (ret_data)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way u_way (
            .clk          (clk),
            .reset        (reset),
            .lookup_index (lookup_index),
            .req_tag      (req_tag),
            .word_sel     (word_sel),
            .refill_we    (refill_we[w]),
            .refill_word  (refill_word),
            .refill_data  (ret_data),
            .tag_we       (tag_we[w]),
            .hit          (way_hit[w]),
            .line_valid   (way_valid[w]),
            .load_word    (way_load_word[w])
        );
    end

    victim_select #(
        .LFSR_SEED (LFSR_SEED)
    ) u_victim (
        .clk       (clk),
        .reset     (reset),
        .way_valid (way_valid),
        .victim    (victim)
    );

endmodule

`default_nettype wire

//--- icache_sva.sv
`default_nettype none

module icache_sva (
    input wire                         clk,
    input wire                         reset,
    input wire                         rd_req,
    input wire                         rd_rdy,
    input wire mem_bus_pkg::req_type_t rd_type,
    input wire mem_bus_pkg::addr_t     rd_addr,
    input wire                         data_ok
);

    timeunit 1ns;
    timeprecision 1ps;

    import mem_bus_pkg::*;

    // an unanswered request stays up with the same address
    property req_held_until_ready;
        @(posedge clk) disable iff (reset)
            (rd_req && !rd_rdy) |=> (rd_req && $stable(rd_addr));
    endproperty

    property line_type_on_req;
        @(posedge clk) disable iff (reset)
            rd_req |-> (rd_type == REQ_LINE);
    endproperty

    // words only come back after the bus took the request
    property no_data_during_req;
        @(posedge clk) disable iff (reset)
            rd_req |-> !data_ok;
    endproperty

    req_held_a: assert property (req_held_until_ready)
        else $error("rd_req dropped or rd_addr changed before rd_rdy");

    line_type_a: assert property (line_type_on_req)
        else $error("rd_type is not a line read while rd_req is high");

    no_data_a: assert property (no_data_during_req)
        else $error("data_ok high while rd_req is high");

endmodule

bind icache_top icache_sva sva_i (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_type (rd_type),
    .rd_addr (rd_addr),
    .data_ok (data_ok)
);

`default_nettype wire

//--- tb_icache.sv
`default_nettype none

module tb_icache;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_bus_pkg::*;

    localparam int    NUM_TESTS    = 24;
    localparam word_t DATA_PATTERN = 32'h5A3C_96E1;

    localparam logic [1:0] MISS = 2'd0;
    localparam logic [1:0] HIT  = 2'd1;
    localparam logic [1:0] ANY  = 2'd2;   // data checked, hit or miss left open

    // three tags that share index 8'h34
    localparam addr_t LINE_A = 32'h0001_2340;
    localparam addr_t LINE_B = 32'h0005_6340;
    localparam addr_t LINE_C = 32'h0009_A340;

    typedef struct packed {
        addr_t      addr;
        logic [1:0] outcome;
        logic       b2b;       // offered in the cycle after the previous acceptance
    } test_t;

    typedef struct {
        int          num;
        addr_t       addr;
        logic [1:0]  outcome;
        logic        b2b;
        int unsigned accept_cycle;
        int          reqs;     // line requests seen before acceptance
    } pending_t;

    localparam test_t TESTS [NUM_TESTS] = '{
        {LINE_A + 32'h4, MISS, 1'b0},   // cold miss on word 1
        {LINE_A + 32'h8, HIT,  1'b0},
        {LINE_A + 32'hC, HIT,  1'b0},
        {LINE_A,         HIT,  1'b0},   // start of a hit stream
        {LINE_A + 32'h4, HIT,  1'b1},
        {LINE_A + 32'h8, HIT,  1'b1},
        {LINE_A + 32'hC, HIT,  1'b1},
        {LINE_B + 32'hC, MISS, 1'b0},   // fills the second way
        {LINE_A + 32'h8, HIT,  1'b0},
        {LINE_B + 32'h4, HIT,  1'b1},
        {LINE_A,         HIT,  1'b1},
        {LINE_C,         MISS, 1'b0},   // set full, random eviction
        {LINE_C + 32'h8, HIT,  1'b0},
        {LINE_A + 32'h4, ANY,  1'b0},
        {LINE_B + 32'h8, ANY,  1'b0},
        {LINE_C + 32'hC, ANY,  1'b0},
        {LINE_A + 32'hC, ANY,  1'b0},
        {LINE_B,         ANY,  1'b0},
        {32'h0000_0FF8,  MISS, 1'b0},   // last set
        {32'hFFFF_F004,  MISS, 1'b0},   // set 0
        {32'hFFFF_F00C,  HIT,  1'b0},
        {32'h1234_5678,  MISS, 1'b0},
        {32'h1234_5670,  HIT,  1'b0},
        {32'h0000_0FF0,  HIT,  1'b1}
    };

    logic        clk;
    logic        reset;
    logic        valid;
    logic [7:0]  index;
    logic [19:0] tag;
    logic [3:0]  offset;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    req_type_t   rd_type;
    addr_t       rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;

    integer      seed = 97353;
    int unsigned cycle = 0;
    int          errors = 0;
    int          line_reqs = 0;
    pending_t    pending [$];

    icache_top #(
        .LFSR_SEED (8'hAA)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .rdata     (rdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

    // memory model, each word is its word address mixed with a pattern
    function automatic word_t mem_word(addr_t addr);
        return (addr >> 2) ^ DATA_PATTERN;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin : watchdog
        repeat (NUM_TESTS * 40) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // line read bus with random rd_rdy delay and gaps between beats
    initial begin : bus_responder
        addr_t line_addr;
        int    wait_cycles;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                line_addr   = rd_addr;
                wait_cycles = $unsigned($random(seed)) % 4;
                repeat (wait_cycles + 1) begin
                    @(posedge clk);
                    #1;
                end
                rd_rdy = 1'b1;
                @(posedge clk);
                #1;
                rd_rdy = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    wait_cycles = $unsigned($random(seed)) % 3;
                    repeat (wait_cycles) begin
                        @(posedge clk);
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = mem_word({line_addr[31:4], 2'(b), 2'b00});
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    initial begin : response_check
        pending_t    rec;
        int unsigned last_accept;
        int          bad;
        logic        refilling;
        last_accept = 0;
        refilling   = 1'b0;
        @(negedge reset);
        @(negedge clk);
        assert (addr_ok && !rd_req && !data_ok) else begin
            $display("ERR %0t: after reset addr_ok %b rd_req %b data_ok %b",
                     $time, addr_ok, rd_req, data_ok);
            errors++;
        end
        forever begin
            @(negedge clk);
            if (rd_req && rd_rdy) begin
                line_reqs++;
                refilling = 1'b1;
                assert (rd_type == REQ_LINE) else begin
                    $display("ERR %0t: rd_type %b is not a line read", $time, rd_type);
                    errors++;
                end
                assert (pending.size() != 0 && rd_addr == {pending[0].addr[31:4], 4'h0})
                else begin
                    $display("ERR %0t: rd_addr %h is not the missed line", $time, rd_addr);
                    errors++;
                end
            end
            // a refill is under way once the hit slot has passed
            if (pending.size() != 0 && cycle > pending[0].accept_cycle + 1) begin
                assert (!addr_ok) else begin
                    $display("ERR %0t: addr_ok high during the miss of test %0d",
                             $time, pending[0].num);
                    errors++;
                end
            end else if (refilling) begin
                assert (!addr_ok) else begin   // requested word already returned
                    $display("ERR %0t: addr_ok high before the last refill beat", $time);
                    errors++;
                end
            end
            if (ret_valid && ret_last) begin
                refilling = 1'b0;
            end
            if (data_ok) begin
                assert (pending.size() != 0) else begin
                    $display("data_ok arrived at %0t with no request outstanding", $time);
                    errors++;
                end
                if (pending.size() != 0) begin
                    rec = pending.pop_front();
                    bad = 0;
                    assert (rdata == mem_word(rec.addr)) else begin
                        $display("ERR %0t: test %0d rdata %h, expected %h",
                                 $time, rec.num, rdata, mem_word(rec.addr));
                        bad++;
                    end
                    if (rec.outcome == HIT) begin
                        assert (cycle == rec.accept_cycle + 1 && line_reqs == rec.reqs)
                        else begin
                            $display("ERR %0t: test %0d not a hit, %0d cycles, %0d requests",
                                     $time, rec.num, cycle - rec.accept_cycle,
                                     line_reqs - rec.reqs);
                            bad++;
                        end
                    end else if (rec.outcome == MISS) begin
                        assert (line_reqs == rec.reqs + 1) else begin
                            $display("ERR %0t: test %0d made %0d line requests, expected 1",
                                     $time, rec.num, line_reqs - rec.reqs);
                            bad++;
                        end
                    end
                    if (rec.b2b) begin
                        assert (rec.accept_cycle == last_accept + 1) else begin
                            $display("ERR %0t: test %0d not accepted right after test %0d",
                                     $time, rec.num, rec.num - 1);
                            bad++;
                        end
                    end
                    last_accept = rec.accept_cycle;
                    errors += bad;
                    $display("test %2d  addr %h  rdata %h  %0d cycles  %s", rec.num,
                             rec.addr, rdata, cycle - rec.accept_cycle,
                             (bad == 0) ? "ok" : "failed");
                end
            end
        end
    end

    initial begin : stimulus
        reset  = 1'b1;
        valid  = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            pending_t entry;
            logic     next_b2b;
            valid = 1'b1;
            {tag, index, offset} = TESTS[i].addr;
            forever begin
                @(negedge clk);
                if (addr_ok) begin
                    break;   // taken at the coming edge
                end
                @(posedge clk);
                #1;
            end
            entry.num          = i;
            entry.addr         = TESTS[i].addr;
            entry.outcome      = TESTS[i].outcome;
            entry.b2b          = TESTS[i].b2b;
            entry.accept_cycle = cycle;
            entry.reqs         = line_reqs;
            pending.push_back(entry);
            @(posedge clk);
            #1;
            next_b2b = (i + 1 < NUM_TESTS) ? TESTS[i + 1].b2b : 1'b0;
            if (!next_b2b) begin
                valid = 1'b0;
                while (pending.size() != 0) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        $display("%0d tests, %0d errors, %0d line requests", NUM_TESTS, errors, line_reqs);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
cache_geom_pkg.sv
mem_bus_pkg.sv
cache_sram.sv
cache_way.sv
victim_select.sv
cache_ctrl.sv
icache_top.sv
icache_sva.sv
tb_icache.sv

//--- Makefile
SOURCES := $(shell cat files.f)

.PHONY: run clean

run: obj_dir/Vtb_icache
	@out="$$(./obj_dir/Vtb_icache)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

obj_dir/Vtb_icache: files.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_icache -f files.f

clean:
	rm -rf obj_dir
